// File: bench/tb_models.svh
// Reference models of host link, sector stream and mixer, included into the testbench module
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// Host link state
logic       m_toggle;
logic [7:0] m_stat_cnt;
logic [7:0] m_comm_cnt;
logic [3:0] m_req_prev;
host_cmd_t  m_cmd;

// Sector stream state
logic [7:0] m_bytes[$];
logic       m_dm;
int         m_len;
int         m_queued;

// Expected mixer outputs, oldest first
stereo_t    m_audio[$];

// Request order is command, data-out, data-end, reset
task automatic model_core_edge(input logic [3:0] req, input logic [95:0] c,
		input logic [79:0] d, input logic fs);
	logic [3:0] rise;
	rise = req & ~m_req_prev;
	m_req_prev = req;
	if (rise[3]) begin
		m_cmd.payload = c;
		m_cmd.kind = {fs, 15'd0};
		m_comm_cnt = m_comm_cnt + 8'd1;
	end else if (rise[2]) begin
		m_cmd.payload[79:0] = d;
		m_cmd.kind = 16'd1;
	end else if (rise[1]) begin
		m_cmd.kind = 16'd2;
	end else if (rise[0]) begin
		m_cmd.kind = 16'd255;
	end
	if (rise != 4'd0)
		m_cmd.toggle = ~m_cmd.toggle;
endtask

// Low byte first, stop once the header length is used up
task automatic model_dl_word(input logic [15:0] w);
	if (m_queued < m_len) begin
		m_bytes.push_back(w[7:0]);
		m_queued++;
		if (m_queued < m_len) begin
			m_bytes.push_back(w[15:8]);
			m_queued++;
		end
	end
endtask

function automatic sample_t mix_channel(input sample_t c, input sample_t p, input sample_t a);
	int s;
	int g;
	s = int'(c) + int'(p) + int'(a);
	g = s + (s >>> 2);
	g = g >>> 2;
	return g[15:0];
endfunction

`endif

// File: bench/tb_pce_cd_glue.sv
// Testbench for the CD glue top level, random stimulus checked against reference models
`timescale 1ns/1ns

module tb_pce_cd_glue
	import cd_glue_pkg::*;
();

	localparam int CNT_W        = 8;
	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	localparam int N_MSGS       = 200;
	localparam int N_REQ_CYCLES = 300;
	localparam int N_DL         = 12;
	localparam int N_AUDIO      = 300;
	// Worst case length of each test in cycles
	localparam int RUN_CYCLES = RESET_CYCLES + 4 + N_MSGS * 6 + N_REQ_CYCLES + 2
		+ N_DL * 130 + N_AUDIO + 4;
	localparam int MARGIN_CYCLES = 500;

	logic                     clk_sys;
	logic                     reset;
	host_msg_t                host_msg;
	logic                     fast_seek;
	logic                     comm_send;
	logic [CMD_PAYLOAD_W-1:0] comm;
	logic                     dout_send;
	logic [DOUT_W-1:0]        dout;
	logic                     data_end;
	logic                     reset_req;
	logic                     dl_active;
	logic                     dl_wr;
	logic [15:0]              dl_data;
	stereo_t                  cdda;
	stereo_t                  psg;
	sample_t                  adpcm;
	host_cmd_t                host_cmd;
	cd_status_t               cd_stat;
	logic                     stat_get;
	logic                     dout_req;
	logic [CNT_W-1:0]         stat_cnt;
	logic [CNT_W-1:0]         comm_cnt;
	logic [7:0]               cd_byte;
	logic                     cd_wr;
	logic                     cd_dm;
	stereo_t                  audio;

	int         errors;
	int         test_start;
	int         tests_passed;
	int         tests_failed;
	logic [7:0] exp_byte;

	`include "tb_models.svh"

	pce_cd_glue #(
		.CNT_W(CNT_W),
		.GUARD(2)
	) dut0 (
		.clk_sys(clk_sys), .reset(reset), .host_msg(host_msg), .fast_seek(fast_seek),
		.comm_send(comm_send), .comm(comm), .dout_send(dout_send), .dout(dout),
		.data_end(data_end), .reset_req(reset_req), .dl_active(dl_active), .dl_wr(dl_wr),
		.dl_data(dl_data), .cdda(cdda), .psg(psg), .adpcm(adpcm), .host_cmd(host_cmd),
		.cd_stat(cd_stat), .stat_get(stat_get), .dout_req(dout_req), .stat_cnt(stat_cnt),
		.comm_cnt(comm_cnt), .cd_byte(cd_byte), .cd_wr(cd_wr), .cd_dm(cd_dm), .audio(audio)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic check_equal(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		assert (actual === expected) else begin
			$display("error at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("At %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic start_test();
		test_start = errors;
	endtask

	task automatic report_test(input string name);
		if (errors == test_start) begin
			tests_passed++;
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", name, errors - test_start);
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	function automatic sample_t rand_sample();
		logic [31:0] r;
		r = $urandom;
		case (r[19:17])
			3'd0: return 16'h7fff;
			3'd1: return 16'h8000;
			3'd2: return 16'hffff;
			default: return r[15:0];
		endcase
	endfunction

	// Every byte write must match the next expected byte
	always @(negedge clk_sys) begin
		if (!reset && cd_wr === 1'b1) begin
			if (m_bytes.size() == 0) begin
				check_true(1'b0, "byte write seen while no byte was expected");
			end else begin
				exp_byte = m_bytes.pop_front();
				check_equal("cd_byte", 128'(exp_byte), 128'(cd_byte));
				check_equal("cd_dm", 128'(m_dm), 128'(cd_dm));
			end
		end
	end

	// ====================
	// Watchdog
	// ====================

	initial begin
		#((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// ====================
	// Stimulus
	// ====================

	initial begin
		logic [31:0] r;
		logic [95:0] wide;
		logic [3:0]  req;
		int          len;
		int          words;
		stereo_t     exp_mix;

		void'($urandom(69));
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		clk_sys = 1'b0;
		reset = 1'b1;
		host_msg = '0;
		fast_seek = 1'b0;
		{comm_send, dout_send, data_end, reset_req} = 4'd0;
		comm = '0;
		dout = '0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_data = '0;
		cdda = '0;
		psg = '0;
		adpcm = '0;
		m_toggle = 1'b0;
		m_stat_cnt = '0;
		m_comm_cnt = '0;
		m_req_prev = '0;
		m_cmd = '0;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		start_test();
		check_equal("stat_get", '0, 128'(stat_get));
		check_equal("dout_req", '0, 128'(dout_req));
		check_equal("cd_wr", '0, 128'(cd_wr));
		check_equal("stat_cnt", '0, 128'(stat_cnt));
		check_equal("comm_cnt", '0, 128'(comm_cnt));
		check_equal("host_cmd", '0, 128'(host_cmd));
		report_test("Test 1 reset state");

		start_test();
		for (int i = 0; i < N_MSGS; i++) begin
			r = $urandom;
			m_toggle = ~m_toggle;
			m_stat_cnt = m_stat_cnt + 8'd1;
			host_msg = {m_toggle, r[16], r[15:0]};
			next_cycle();
			check_equal("cd_stat", 128'(r[15:0]), 128'(cd_stat));
			check_equal("stat_get", 128'(!r[16]), 128'(stat_get));
			check_equal("dout_req", 128'(r[16]), 128'(dout_req));
			check_equal("stat_cnt", 128'(m_stat_cnt), 128'(stat_cnt));
			repeat ($urandom_range(4, 1)) begin
				next_cycle();
				check_true(!stat_get && !dout_req, "request pulse longer than one cycle");
			end
		end
		report_test("Test 2 host messages");

		start_test();
		for (int i = 0; i < N_REQ_CYCLES; i++) begin
			r = $urandom;
			// Lines low three times in four, so rises are frequent
			req = r[3:0] & r[7:4];
			{comm_send, dout_send, data_end, reset_req} = req;
			fast_seek = r[8];
			comm = {$urandom, $urandom, $urandom};
			wide = {$urandom, $urandom, $urandom};
			dout = wide[79:0];
			model_core_edge(req, comm, dout, fast_seek);
			next_cycle();
			check_equal("host_cmd", 128'(m_cmd), 128'(host_cmd));
			check_equal("comm_cnt", 128'(m_comm_cnt), 128'(comm_cnt));
		end
		{comm_send, dout_send, data_end, reset_req} = 4'd0;
		report_test("Test 3 core requests");

		start_test();
		for (int d = 0; d < N_DL; d++) begin
			dl_active = 1'b0;
			next_cycle();
			dl_active = 1'b1;
			next_cycle();
			next_cycle();
			r = $urandom;
			len = $urandom_range(20, 1);
			m_dm = r[0];
			m_len = len;
			m_queued = 0;
			dl_data = {r[0], 15'(len)};
			dl_wr = 1'b1;
			next_cycle();
			dl_wr = 1'b0;
			// Sometimes one word past the length, which must be ignored
			words = (len + 1) / 2 + int'(r[1]);
			for (int w = 0; w < words; w++) begin
				repeat ($urandom_range(8, 5)) next_cycle();
				r = $urandom;
				dl_data = r[15:0];
				dl_wr = 1'b1;
				model_dl_word(dl_data);
				next_cycle();
				dl_wr = 1'b0;
			end
			repeat (10) next_cycle();
			check_true(m_bytes.size() == 0, "expected stream bytes were never written");
			m_bytes.delete();
		end
		dl_active = 1'b0;
		report_test("Test 4 sector stream");

		start_test();
		m_audio.delete();
		for (int i = 0; i < N_AUDIO; i++) begin
			cdda = {rand_sample(), rand_sample()};
			psg = {rand_sample(), rand_sample()};
			adpcm = rand_sample();
			m_audio.push_back({mix_channel(cdda.left, psg.left, adpcm),
				mix_channel(cdda.right, psg.right, adpcm)});
			next_cycle();
			if (m_audio.size() >= 2) begin
				exp_mix = m_audio.pop_front();
				check_equal("audio", 128'(exp_mix), 128'(audio));
			end
		end
		next_cycle();
		exp_mix = m_audio.pop_front();
		check_equal("audio", 128'(exp_mix), 128'(audio));
		report_test("Test 5 audio mixing");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: rtl/audio_mixer.sv
// Two-stage stereo mix of CD audio, PSG and ADPCM with a 1.25 gain
`timescale 1ns/1ns

module audio_mixer
	import cd_glue_pkg::*;
#(
	parameter int GUARD = 2
) (
	input  logic    clk_sys,
	input  stereo_t cdda,
	input  stereo_t psg,
	input  sample_t adpcm,
	output stereo_t audio
);

	localparam int ACC_W = $bits(sample_t) + GUARD;

	logic signed [ACC_W-1:0] pre_l;
	logic signed [ACC_W-1:0] pre_r;
	logic signed [ACC_W-1:0] mix_l;
	logic signed [ACC_W-1:0] mix_r;

	function automatic logic signed [ACC_W-1:0] ext(input sample_t s);
		return {{GUARD{s[$bits(sample_t)-1]}}, s};
	endfunction

	always_ff @(posedge clk_sys) begin
		// Stage one, raw sum; ADPCM is mono and feeds both sides
		pre_l <= ext(cdda.left) + ext(psg.left) + ext(adpcm);
		pre_r <= ext(cdda.right) + ext(psg.right) + ext(adpcm);

		// Stage two, x1.25 so the full sum range fills the output
		mix_l <= pre_l + (pre_l >>> 2);
		mix_r <= pre_r + (pre_r >>> 2);
	end

	// Drop the guard bits, wraps on overflow
	assign audio.left  = mix_l[ACC_W-1:GUARD];
	assign audio.right = mix_r[ACC_W-1:GUARD];

endmodule

// File: rtl/cd_data_stream.sv
// Turns a host sector download (header word then data words) into CD byte writes
`timescale 1ns/1ns

module cd_data_stream (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,
	input  logic        dl_wr,
	input  logic [15:0] dl_data,
	output logic [7:0]  cd_byte,
	output logic        cd_wr,
	output logic        cd_dm
);

	logic        dl_active_q;
	logic        head_seen;
	logic        wr_pend;
	logic        byte_sel;
	logic [14:0] byte_len;
	logic [14:0] byte_cnt;
	logic [15:0] word_q;

	// Low byte goes out first
	assign cd_byte = byte_sel ? word_q[15:8] : word_q[7:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			head_seen   <= 1'b0;
			byte_len    <= '0;
			byte_cnt    <= '0;
			wr_pend     <= 1'b0;
			byte_sel    <= 1'b0;
			cd_wr       <= 1'b0;
			cd_dm       <= 1'b0;
		end else begin
			dl_active_q <= dl_active;

			// ====================
			// Word intake
			// ====================
			if (dl_active && !dl_active_q) begin
				head_seen <= 1'b0;
				byte_len  <= '0;
				byte_cnt  <= '0;
			end else if (dl_wr && dl_active) begin
				if (!head_seen) begin
					{cd_dm, byte_len} <= dl_data;
					byte_cnt          <= '0;
					head_seen         <= 1'b1;
				end else if (byte_cnt < byte_len) begin
					word_q   <= dl_data;
					wr_pend  <= 1'b1;
					byte_sel <= 1'b0;
				end
			end

			// ====================
			// Byte output
			// ====================
			if (wr_pend) begin
				if (!cd_wr) begin
					cd_wr <= 1'b1;
				end else begin
					cd_wr    <= 1'b0;
					byte_sel <= ~byte_sel;
					byte_cnt <= byte_cnt + 15'd1;
					// Done after the high byte or once length is reached
					if (byte_sel || byte_cnt >= byte_len - 15'd1)
						wr_pend <= 1'b0;
				end
			end
		end
	end

endmodule

// File: rtl/cd_glue_pkg.sv
// Shared widths, message structs and command kind codes for the CD glue blocks
package cd_glue_pkg;

	// ====================
	// Audio
	// ====================

	typedef logic signed [15:0] sample_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Accumulator width of the mixer, two bits of headroom over a sample
	localparam int MIX_W = 18;

	// ====================
	// Host messages
	// ====================

	// Message byte on top, drive status byte below
	typedef struct packed {
		logic [7:0] msg;
		logic [7:0] stat;
	} cd_status_t;

	// Host to core, new message when toggle flips
	typedef struct packed {
		logic       toggle;
		logic       data_req;
		cd_status_t status;
	} host_msg_t;

	localparam int CMD_PAYLOAD_W = 96;
	localparam int DOUT_W = 80;

	// Core to host, same toggle scheme
	typedef struct packed {
		logic                     toggle;
		logic [15:0]              kind;
		logic [CMD_PAYLOAD_W-1:0] payload;
	} host_cmd_t;

	// Command kinds, fast seek rides in bit 15 of KIND_COMMAND
	localparam logic [15:0] KIND_COMMAND = 16'h0000;
	localparam logic [15:0] KIND_DATAOUT = 16'h0001;
	localparam logic [15:0] KIND_DATAEND = 16'h0002;
	localparam logic [15:0] KIND_RESET   = 16'h00ff;

endpackage

// File: rtl/cd_host_link.sv
// Toggle-based message exchange between the console CD core and the host, with counters
`timescale 1ns/1ns

module cd_host_link
	import cd_glue_pkg::*;
#(
	parameter int CNT_W = 8
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  host_msg_t                host_msg,
	input  logic                     fast_seek,
	input  logic                     comm_send,
	input  logic [CMD_PAYLOAD_W-1:0] comm,
	input  logic                     dout_send,
	input  logic [DOUT_W-1:0]        dout,
	input  logic                     data_end,
	input  logic                     reset_req,
	output host_cmd_t                host_cmd,
	output cd_status_t               cd_stat,
	output logic                     stat_get,
	output logic                     dout_req,
	output logic [CNT_W-1:0]         stat_cnt,
	output logic [CNT_W-1:0]         comm_cnt
);

	// Request line positions, highest priority first
	localparam int REQ_COMM  = 3;
	localparam int REQ_DOUT  = 2;
	localparam int REQ_DEND  = 1;
	localparam int REQ_RESET = 0;

	logic       toggle_seen;
	logic       msg_new;
	logic [3:0] req_now;
	logic [3:0] req_q;
	logic [3:0] req_rise;

	assign msg_new  = host_msg.toggle != toggle_seen;
	assign req_now  = {comm_send, dout_send, data_end, reset_req};
	assign req_rise = req_now & ~req_q;

	// ====================
	// Host to core
	// ====================

	always_ff @(posedge clk_sys) begin
		stat_get <= 1'b0;
		dout_req <= 1'b0;
		if (reset) begin
			toggle_seen <= 1'b0;
			stat_cnt    <= '0;
		end else if (msg_new) begin
			toggle_seen <= host_msg.toggle;
			// Exactly one of the two pulses
			stat_get    <= ~host_msg.data_req;
			dout_req    <= host_msg.data_req;
			stat_cnt    <= stat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (msg_new)
			cd_stat <= host_msg.status;
	end

	// ====================
	// Core to host
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_q    <= '0;
			host_cmd <= '0;
			comm_cnt <= '0;
		end else begin
			req_q <= req_now;
			// Losing edges are dropped, not queued
			if (req_rise[REQ_COMM]) begin
				host_cmd.payload <= comm;
				host_cmd.kind    <= KIND_COMMAND | {fast_seek, 15'd0};
				host_cmd.toggle  <= ~host_cmd.toggle;
				comm_cnt         <= comm_cnt + 1'b1;
			end else if (req_rise[REQ_DOUT]) begin
				// Upper payload bits keep the last command
				host_cmd.payload[DOUT_W-1:0] <= dout;
				host_cmd.kind                <= KIND_DATAOUT;
				host_cmd.toggle              <= ~host_cmd.toggle;
			end else if (req_rise[REQ_DEND]) begin
				host_cmd.kind   <= KIND_DATAEND;
				host_cmd.toggle <= ~host_cmd.toggle;
			end else if (req_rise[REQ_RESET]) begin
				host_cmd.kind   <= KIND_RESET;
				host_cmd.toggle <= ~host_cmd.toggle;
			end
		end
	end

endmodule

// File: rtl/pce_cd_glue.sv
// CD glue top level: host link, sector stream and audio mixer for the console core
`timescale 1ns/1ns

module pce_cd_glue
	import cd_glue_pkg::*;
#(
	parameter int CNT_W = 8,
	// Mixer headroom bits over a 16-bit sample
	parameter int GUARD = MIX_W - $bits(sample_t)
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  host_msg_t                host_msg,
	input  logic                     fast_seek,
	input  logic                     comm_send,
	input  logic [CMD_PAYLOAD_W-1:0] comm,
	input  logic                     dout_send,
	input  logic [DOUT_W-1:0]        dout,
	input  logic                     data_end,
	input  logic                     reset_req,
	input  logic                     dl_active,
	input  logic                     dl_wr,
	input  logic [15:0]              dl_data,
	input  stereo_t                  cdda,
	input  stereo_t                  psg,
	input  sample_t                  adpcm,
	output host_cmd_t                host_cmd,
	output cd_status_t               cd_stat,
	output logic                     stat_get,
	output logic                     dout_req,
	output logic [CNT_W-1:0]         stat_cnt,
	output logic [CNT_W-1:0]         comm_cnt,
	output logic [7:0]               cd_byte,
	output logic                     cd_wr,
	output logic                     cd_dm,
	output stereo_t                  audio
);

	// ====================
	// Host link
	// ====================

	cd_host_link #(
		.CNT_W(CNT_W)
	) link0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.host_msg  (host_msg),
		.fast_seek (fast_seek),
		.comm_send (comm_send),
		.comm      (comm),
		.dout_send (dout_send),
		.dout      (dout),
		.data_end  (data_end),
		.reset_req (reset_req),
		.host_cmd  (host_cmd),
		.cd_stat   (cd_stat),
		.stat_get  (stat_get),
		.dout_req  (dout_req),
		.stat_cnt  (stat_cnt),
		.comm_cnt  (comm_cnt)
	);

	// Sector data from the host download
	cd_data_stream stream0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.cd_byte   (cd_byte),
		.cd_wr     (cd_wr),
		.cd_dm     (cd_dm)
	);

	// ====================
	// Audio
	// ====================

	audio_mixer #(
		.GUARD(GUARD)
	) mixer0 (
		.clk_sys (clk_sys),
		.cdda    (cdda),
		.psg     (psg),
		.adpcm   (adpcm),
		.audio   (audio)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the CD glue testbench with Verilator, exit status 0 only on pass

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ns -f sim.f \
	--top-module tb_pce_cd_glue -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_pce_cd_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim.f
+incdir+bench
rtl/cd_glue_pkg.sv
rtl/cd_host_link.sv
rtl/cd_data_stream.sv
rtl/audio_mixer.sv
rtl/pce_cd_glue.sv
bench/tb_pce_cd_glue.sv
